/* rtl/led_ctrl_pkg.sv */
package led_ctrl_pkg;

    // matrix geometry
    localparam int PIXEL_WIDTH = 64;
    localparam int PIXEL_HEIGHT = 32;
    localparam int BYTES_PER_PIXEL = 2;    // RGB565

    // row, then column, then byte select
    localparam int FB_ADDR_BITS = $clog2(PIXEL_HEIGHT) + $clog2(PIXEL_WIDTH)
                                + $clog2(BYTES_PER_PIXEL);

    typedef logic [7:0] byte_t;
    typedef logic [$clog2(PIXEL_HEIGHT)-1:0] row_t;
    typedef logic [$clog2(PIXEL_WIDTH)-1:0] col_t;
    typedef logic [FB_ADDR_BITS-1:0] fb_addr_t;

    typedef enum logic [1:0] {
        IDLE,
        LOAD_ROW,
        LOAD_PIXEL
    } cmd_state_e;

    // shared frame buffer write port
    typedef struct packed {
        logic     req;
        fb_addr_t addr;
        byte_t    data;
    } fb_wr_t;

endpackage

/* rtl/framebuffer.sv */
`timescale 1ns/10ps

module framebuffer (
    input  logic                   clk_in,
    input  led_ctrl_pkg::fb_wr_t   fb_wr,
    input  led_ctrl_pkg::fb_addr_t rd_addr,
    output led_ctrl_pkg::byte_t    rd_data
);
    localparam int DEPTH = 2 ** led_ctrl_pkg::FB_ADDR_BITS;

    led_ctrl_pkg::byte_t mem [DEPTH];

    always_ff @(posedge clk_in) begin
        if (fb_wr.req) begin
            mem[fb_wr.addr] <= fb_wr.data;
        end
    end

    // scan-out side, one cycle latency
    always_ff @(posedge clk_in) begin
        rd_data <= mem[rd_addr];
    end

endmodule

/* rtl/fb_write_arbiter.sv */
`timescale 1ns/10ps

module fb_write_arbiter (
    input  logic                 clk_in,
    input  logic                 reset,
    input  led_ctrl_pkg::fb_wr_t row_wr,
    input  led_ctrl_pkg::fb_wr_t pixel_wr,
    output led_ctrl_pkg::fb_wr_t fb_wr
);

    // fixed priority, row handler first
    always_ff @(posedge clk_in) begin
        if (reset) begin
            fb_wr.req <= 1'b0;
        end else begin
            if (row_wr.req) begin
                fb_wr <= row_wr;
            end else if (pixel_wr.req) begin
                fb_wr <= pixel_wr;
            end else begin
                fb_wr.req <= 1'b0;    // addr and data hold
            end
        end
    end

    // decoder enables one handler at a time
    assert property (@(posedge clk_in) disable iff (reset)
        !(row_wr.req && pixel_wr.req));

endmodule

/* rtl/cmd_load_pixel.sv */
`timescale 1ns/10ps

module cmd_load_pixel (
    input  logic                 clk_in,
    input  logic                 reset,
    input  logic                 active,
    input  logic                 byte_strobe,
    input  led_ctrl_pkg::byte_t  byte_data,
    output led_ctrl_pkg::fb_wr_t wr,
    output logic                 done
);
    logic [1:0]           step;    // row, column, high byte, low byte
    led_ctrl_pkg::row_t   row;
    led_ctrl_pkg::col_t   col;
    led_ctrl_pkg::fb_wr_t wr_q;
    logic                 take;

    assign take = active && byte_strobe;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            step <= 2'd0;
            wr_q.req <= 1'b0;
            wr.req <= 1'b0;
            done <= 1'b0;
        end else begin
            wr_q.req <= 1'b0;
            done <= 1'b0;
            wr <= wr_q;
            if (take) begin
                step <= step + 2'd1;    // wraps to 0 after the low byte
                case (step)
                    2'd0: row <= led_ctrl_pkg::row_t'(byte_data);
                    2'd1: col <= led_ctrl_pkg::col_t'(byte_data);
                    default: begin
                        wr_q.req <= 1'b1;
                        wr_q.addr <= {row, col, ~step[0]};    // step 2 -> select 1
                        wr_q.data <= byte_data;
                        done <= (step == 2'd3);
                    end
                endcase
            end
        end
    end

endmodule

/* rtl/cmd_load_row.sv */
`timescale 1ns/10ps

module cmd_load_row (
    input  logic                 clk_in,
    input  logic                 reset,
    input  logic                 active,
    input  logic                 byte_strobe,
    input  led_ctrl_pkg::byte_t  byte_data,
    output led_ctrl_pkg::fb_wr_t wr,
    output logic                 done
);
    localparam int ROW_BYTES = led_ctrl_pkg::PIXEL_WIDTH * led_ctrl_pkg::BYTES_PER_PIXEL;
    localparam int CNT_BITS = $clog2(ROW_BYTES) + 1;

    logic [CNT_BITS-1:0]  data_cnt;    // data bytes taken so far
    logic                 have_row;
    led_ctrl_pkg::row_t   row;
    led_ctrl_pkg::fb_wr_t wr_q;        // sample stage ahead of wr
    logic                 take;

    assign take = active && byte_strobe;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            data_cnt <= '0;
            have_row <= 1'b0;
            wr_q.req <= 1'b0;
            wr.req <= 1'b0;
            done <= 1'b0;
        end else begin
            wr_q.req <= 1'b0;
            done <= 1'b0;
            wr <= wr_q;
            if (take && !have_row) begin
                row <= led_ctrl_pkg::row_t'(byte_data);    // low row bits only
                have_row <= 1'b1;
            end else if (take) begin
                wr_q.req <= 1'b1;
                // even count is the high byte
                wr_q.addr <= {row, led_ctrl_pkg::col_t'(data_cnt >> 1), ~data_cnt[0]};
                wr_q.data <= byte_data;
                if (data_cnt == CNT_BITS'(ROW_BYTES - 1)) begin
                    data_cnt <= '0;
                    have_row <= 1'b0;
                    done <= 1'b1;
                end else begin
                    data_cnt <= data_cnt + 1'b1;
                end
            end
        end
    end

    assert property (@(posedge clk_in) disable iff (reset)
        data_cnt <= CNT_BITS'(ROW_BYTES));

endmodule

/* rtl/cmd_decoder.sv */
`timescale 1ns/10ps

module cmd_decoder #(
    parameter int BRIGHTNESS_LEVELS = 6
) (
    input  logic                         clk_in,
    input  logic                         reset,
    input  logic                         byte_strobe,
    input  led_ctrl_pkg::byte_t          byte_data,
    input  logic                         row_done,
    input  logic                         pixel_done,
    output logic                         load_row_active,
    output logic                         load_pixel_active,
    output logic [2:0]                   rgb_enable,
    output logic [BRIGHTNESS_LEVELS-1:0] brightness_enable
);
    led_ctrl_pkg::cmd_state_e state;

    assign load_row_active = (state == led_ctrl_pkg::LOAD_ROW);
    assign load_pixel_active = (state == led_ctrl_pkg::LOAD_PIXEL);

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state <= led_ctrl_pkg::IDLE;
            rgb_enable <= 3'b111;
            brightness_enable <= '1;
        end else begin
            case (state)
                led_ctrl_pkg::IDLE: begin
                    if (byte_strobe) begin
                        case (byte_data)
                            "R": rgb_enable[0] <= 1'b1;
                            "r": rgb_enable[0] <= 1'b0;
                            "G": rgb_enable[1] <= 1'b1;
                            "g": rgb_enable[1] <= 1'b0;
                            "B": rgb_enable[2] <= 1'b1;
                            "b": rgb_enable[2] <= 1'b0;
                            "0": brightness_enable <= '0;
                            "9": brightness_enable <= '1;
                            "L": state <= led_ctrl_pkg::LOAD_ROW;
                            "P": state <= led_ctrl_pkg::LOAD_PIXEL;
                            default: begin
                                // digit k flips plane BRIGHTNESS_LEVELS-k
                                for (int k = 1; k <= BRIGHTNESS_LEVELS; k++) begin
                                    if (byte_data == led_ctrl_pkg::byte_t'("0" + k)) begin
                                        brightness_enable[BRIGHTNESS_LEVELS-k] <=
                                            ~brightness_enable[BRIGHTNESS_LEVELS-k];
                                    end
                                end
                            end
                        endcase
                    end
                end
                led_ctrl_pkg::LOAD_ROW: begin
                    if (row_done) begin
                        state <= led_ctrl_pkg::IDLE;
                    end
                end
                led_ctrl_pkg::LOAD_PIXEL: begin
                    if (pixel_done) begin
                        state <= led_ctrl_pkg::IDLE;
                    end
                end
                default: state <= led_ctrl_pkg::IDLE;
            endcase
        end
    end

    // done must come from the handler that holds the stream
    assert property (@(posedge clk_in) disable iff (reset)
        row_done |-> load_row_active);
    assert property (@(posedge clk_in) disable iff (reset)
        pixel_done |-> load_pixel_active);

endmodule

/* rtl/led_ctrl_top.sv */
`timescale 1ns/10ps

module led_ctrl_top #(
    parameter int BRIGHTNESS_LEVELS = 6
) (
    input  logic                         clk_in,
    input  logic                         reset,
    input  logic                         byte_strobe,
    input  led_ctrl_pkg::byte_t          byte_data,
    input  led_ctrl_pkg::fb_addr_t       rd_addr,
    output led_ctrl_pkg::byte_t          rd_data,
    output logic [2:0]                   rgb_enable,
    output logic [BRIGHTNESS_LEVELS-1:0] brightness_enable
);
    logic load_row_active;
    logic load_pixel_active;
    logic row_done;
    logic pixel_done;
    led_ctrl_pkg::fb_wr_t row_wr;
    led_ctrl_pkg::fb_wr_t pixel_wr;
    led_ctrl_pkg::fb_wr_t fb_wr;

    cmd_decoder #(
        .BRIGHTNESS_LEVELS(BRIGHTNESS_LEVELS)
    ) cmd_decoder_inst (
        .clk_in(clk_in),
        .reset(reset),
        .byte_strobe(byte_strobe),
        .byte_data(byte_data),
        .row_done(row_done),
        .pixel_done(pixel_done),
        .load_row_active(load_row_active),
        .load_pixel_active(load_pixel_active),
        .rgb_enable(rgb_enable),
        .brightness_enable(brightness_enable)
    );

    cmd_load_row cmd_load_row_inst (
        .clk_in(clk_in),
        .reset(reset),
        .active(load_row_active),
        .byte_strobe(byte_strobe),
        .byte_data(byte_data),
        .wr(row_wr),
        .done(row_done)
    );

    cmd_load_pixel cmd_load_pixel_inst (
        .clk_in(clk_in),
        .reset(reset),
        .active(load_pixel_active),
        .byte_strobe(byte_strobe),
        .byte_data(byte_data),
        .wr(pixel_wr),
        .done(pixel_done)
    );

    fb_write_arbiter fb_write_arbiter_inst (
        .clk_in(clk_in),
        .reset(reset),
        .row_wr(row_wr),
        .pixel_wr(pixel_wr),
        .fb_wr(fb_wr)
    );

    framebuffer framebuffer_inst (
        .clk_in(clk_in),
        .fb_wr(fb_wr),
        .rd_addr(rd_addr),
        .rd_data(rd_data)
    );

endmodule

/* testbench/tb_clock.sv */
`timescale 1ns/10ps

module tb_clock #(
    parameter real PERIOD_NS = 4.0
) (
    output logic clk_in
);
    initial begin
        clk_in = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0) clk_in = ~clk_in;
        end
    end

endmodule

/* testbench/led_ctrl_tb.sv */
`timescale 1ns/10ps

module led_ctrl_tb;
    localparam int BRIGHTNESS_LEVELS = 6;
    localparam int ROW_BYTES = led_ctrl_pkg::PIXEL_WIDTH * led_ctrl_pkg::BYTES_PER_PIXEL;
    localparam int SETTLE_CYCLES = 20;

    logic                         clk_in;
    logic                         reset;
    logic                         byte_strobe;
    led_ctrl_pkg::byte_t          byte_data;
    led_ctrl_pkg::fb_addr_t       rd_addr;
    led_ctrl_pkg::byte_t          rd_data;
    logic [2:0]                   rgb_enable;
    logic [BRIGHTNESS_LEVELS-1:0] brightness_enable;

    // reference state built from the command rules
    logic [2:0]                   rgb_model;
    logic [BRIGHTNESS_LEVELS-1:0] bright_model;
    led_ctrl_pkg::byte_t          fb_model [2 ** led_ctrl_pkg::FB_ADDR_BITS];

    integer seed = 62493;
    int     test_errors;
    int     tests_passed;
    int     tests_failed;

    tb_clock clock_gen (.clk_in(clk_in));

    led_ctrl_top #(
        .BRIGHTNESS_LEVELS(BRIGHTNESS_LEVELS)
    ) led_ctrl_top_inst (
        .clk_in(clk_in),
        .reset(reset),
        .byte_strobe(byte_strobe),
        .byte_data(byte_data),
        .rd_addr(rd_addr),
        .rd_data(rd_data),
        .rgb_enable(rgb_enable),
        .brightness_enable(brightness_enable)
    );

    function automatic led_ctrl_pkg::fb_addr_t fb_addr(input led_ctrl_pkg::row_t row,
                                                       input led_ctrl_pkg::col_t col,
                                                       input logic sel);
        return {row, col, sel};    // row, column, byte select
    endfunction

    function automatic void model_command(input led_ctrl_pkg::byte_t cmd);
        int k;
        k = int'(cmd) - int'("0");
        case (cmd)
            "R": rgb_model[0] = 1'b1;
            "r": rgb_model[0] = 1'b0;
            "G": rgb_model[1] = 1'b1;
            "g": rgb_model[1] = 1'b0;
            "B": rgb_model[2] = 1'b1;
            "b": rgb_model[2] = 1'b0;
            "0": bright_model = '0;
            "9": bright_model = '1;
            default: begin
                if (k >= 1 && k <= BRIGHTNESS_LEVELS) begin
                    bright_model[BRIGHTNESS_LEVELS-k] = ~bright_model[BRIGHTNESS_LEVELS-k];
                end
            end
        endcase
    endfunction

    task automatic report_mismatch(input string test, input string what,
                                   input logic [31:0] expected, input logic [31:0] actual);
        $display("Error: %s %s expected %0h actual %0h", test, what, expected, actual);
        test_errors++;
    endtask

    // called on a falling edge, returns on a falling edge
    task automatic send_byte(input led_ctrl_pkg::byte_t value);
        byte_strobe = 1'b1;
        byte_data = value;
        @(negedge clk_in);
        byte_strobe = 1'b0;
        repeat (3) @(negedge clk_in);
    endtask

    task automatic read_fb(input led_ctrl_pkg::fb_addr_t addr, output led_ctrl_pkg::byte_t value);
        rd_addr = addr;
        @(negedge clk_in);
        value = rd_data;
    endtask

    task automatic check_fb(input string test, input led_ctrl_pkg::fb_addr_t addr);
        led_ctrl_pkg::byte_t value;
        read_fb(addr, value);
        if (value !== fb_model[addr]) begin
            report_mismatch(test, $sformatf("fb[%0h]", addr), fb_model[addr], value);
        end
    endtask

    task automatic check_enables(input string test);
        int cycles;
        cycles = 0;
        while ((rgb_enable !== rgb_model || brightness_enable !== bright_model)
               && cycles < SETTLE_CYCLES) begin
            @(negedge clk_in);
            cycles++;
        end
        if (rgb_enable !== rgb_model || brightness_enable !== bright_model) begin
            $display("%s: enables did not settle within %0d cycles", test, SETTLE_CYCLES);
        end
        if (rgb_enable !== rgb_model) begin
            report_mismatch(test, "rgb_enable", rgb_model, rgb_enable);
        end
        if (brightness_enable !== bright_model) begin
            report_mismatch(test, "brightness_enable", bright_model, brightness_enable);
        end
    endtask

    task automatic wait_decoder_idle(input string test);
        int cycles;
        cycles = 0;
        while ((led_ctrl_top_inst.load_row_active || led_ctrl_top_inst.load_pixel_active)
               && cycles < SETTLE_CYCLES) begin
            @(negedge clk_in);
            cycles++;
        end
        if (led_ctrl_top_inst.load_row_active || led_ctrl_top_inst.load_pixel_active) begin
            $display("%s: decoder did not return to idle within %0d cycles", test, SETTLE_CYCLES);
            test_errors++;
        end
    endtask

    task automatic send_command(input string test, input led_ctrl_pkg::byte_t cmd);
        send_byte(cmd);
        model_command(cmd);
        check_enables(test);
    endtask

    task automatic finish_test(input string test);
        if (test_errors == 0) begin
            $display("%s: ok", test);
            tests_passed++;
        end else begin
            $display("%s: %0d errors", test, test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    task automatic test_reset_values();
        check_enables("reset_values");
        finish_test("reset_values");
    endtask

    task automatic test_color_commands();
        string seq = "rRgGbxB?b~B";
        for (int i = 0; i < seq.len(); i++) begin
            send_command("color_commands", seq[i]);
        end
        finish_test("color_commands");
    endtask

    task automatic test_brightness_commands();
        string seq = "136702594";    // 7 is out of range with 6 planes
        for (int i = 0; i < seq.len(); i++) begin
            send_command("brightness_commands", seq[i]);
        end
        finish_test("brightness_commands");
    endtask

    task automatic load_pixel(input string test, input led_ctrl_pkg::byte_t row_byte,
                              input led_ctrl_pkg::byte_t col_byte,
                              input led_ctrl_pkg::byte_t hi, input led_ctrl_pkg::byte_t lo);
        led_ctrl_pkg::row_t row;
        led_ctrl_pkg::col_t col;
        row = led_ctrl_pkg::row_t'(row_byte);
        col = led_ctrl_pkg::col_t'(col_byte);
        send_byte("P");
        send_byte(row_byte);
        send_byte(col_byte);
        send_byte(hi);
        send_byte(lo);
        fb_model[fb_addr(row, col, 1'b1)] = hi;    // high byte first
        fb_model[fb_addr(row, col, 1'b0)] = lo;
        wait_decoder_idle(test);
        check_fb(test, fb_addr(row, col, 1'b1));
        check_fb(test, fb_addr(row, col, 1'b0));
    endtask

    task automatic test_pixel_load();
        led_ctrl_pkg::byte_t    row_byte;
        led_ctrl_pkg::byte_t    col_byte;
        led_ctrl_pkg::byte_t    left_before;
        led_ctrl_pkg::byte_t    right_before;
        led_ctrl_pkg::byte_t    value;
        led_ctrl_pkg::fb_addr_t left_addr;
        led_ctrl_pkg::fb_addr_t right_addr;
        row_byte = led_ctrl_pkg::byte_t'($random(seed));
        col_byte = led_ctrl_pkg::byte_t'($random(seed));
        left_addr = fb_addr(led_ctrl_pkg::row_t'(row_byte),
                            led_ctrl_pkg::col_t'(col_byte - 8'd1), 1'b1);
        right_addr = fb_addr(led_ctrl_pkg::row_t'(row_byte),
                             led_ctrl_pkg::col_t'(col_byte + 8'd1), 1'b0);
        read_fb(left_addr, left_before);
        read_fb(right_addr, right_before);
        load_pixel("pixel_load", row_byte, col_byte, led_ctrl_pkg::byte_t'($random(seed)),
                   led_ctrl_pkg::byte_t'($random(seed)));
        read_fb(left_addr, value);
        if (value !== left_before) begin
            report_mismatch("pixel_load", "left neighbor", left_before, value);
        end
        read_fb(right_addr, value);
        if (value !== right_before) begin
            report_mismatch("pixel_load", "right neighbor", right_before, value);
        end
        finish_test("pixel_load");
    endtask

    task automatic test_row_load();
        led_ctrl_pkg::byte_t row_byte;
        led_ctrl_pkg::byte_t data;
        led_ctrl_pkg::row_t  row;
        send_command("row_load", "r");    // so a later R is visible
        row_byte = led_ctrl_pkg::byte_t'($random(seed));
        row = led_ctrl_pkg::row_t'(row_byte);
        send_byte("L");
        send_byte(row_byte);
        for (int i = 0; i < ROW_BYTES; i++) begin
            data = led_ctrl_pkg::byte_t'($random(seed));
            fb_model[fb_addr(row, led_ctrl_pkg::col_t'(i / 2), (i % 2) == 0)] = data;
            send_byte(data);
        end
        wait_decoder_idle("row_load");
        check_enables("row_load");    // data bytes are never decoded
        for (int i = 0; i < ROW_BYTES; i++) begin
            check_fb("row_load", fb_addr(row, led_ctrl_pkg::col_t'(i / 2), (i % 2) == 0));
        end
        send_command("row_load", "R");
        finish_test("row_load");
    endtask

    task automatic test_command_bytes_as_data();
        send_command("command_bytes_as_data", "r");
        load_pixel("command_bytes_as_data", led_ctrl_pkg::byte_t'($random(seed)),
                   led_ctrl_pkg::byte_t'($random(seed)), "R", "0");
        check_enables("command_bytes_as_data");
        finish_test("command_bytes_as_data");
    endtask

    initial begin
        reset = 1'b1;
        byte_strobe = 1'b0;
        byte_data = '0;
        rd_addr = '0;
        test_errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        rgb_model = 3'b111;
        bright_model = '1;
        repeat (2) @(posedge clk_in);
        @(negedge clk_in);
        reset = 1'b0;

        test_reset_values();
        test_color_commands();
        test_brightness_commands();
        test_pixel_load();
        test_row_load();
        test_command_bytes_as_data();

        $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* led_ctrl.f */
rtl/led_ctrl_pkg.sv
rtl/framebuffer.sv
rtl/fb_write_arbiter.sv
rtl/cmd_load_pixel.sv
rtl/cmd_load_row.sv
rtl/cmd_decoder.sv
rtl/led_ctrl_top.sv
testbench/tb_clock.sv
testbench/led_ctrl_tb.sv

/* Makefile */
TB_TOP = led_ctrl_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f led_ctrl.f --top-module led_ctrl_top
	verilator --lint-only --timing --assert -f led_ctrl.f --top-module $(TB_TOP)

sim:
	verilator --binary --timing --assert -f led_ctrl.f --top-module $(TB_TOP) \
		-Mdir obj_dir -o sim_$(TB_TOP)
	./obj_dir/sim_$(TB_TOP) | tee sim.log
	grep -q "^Regression passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
